// ==== Bender.yml ====
package:
  name: debug_unit

sources:
  - files:
      - hdl/dbg_pkg.sv
      - hdl/byte_fifo.sv
      - hdl/cmd_loader.sv
      - hdl/state_dumper.sv
      - hdl/debug_unit.sv

  - target: test
    files:
      - dv/debug_unit_checker.sv
      - dv/debug_unit_tb.sv

// ==== debug_unit.f ====
hdl/dbg_pkg.sv
hdl/byte_fifo.sv
hdl/cmd_loader.sv
hdl/state_dumper.sv
hdl/debug_unit.sv
dv/debug_unit_checker.sv
dv/debug_unit_tb.sv

// ==== dv/debug_unit_checker.sv ====
`timescale 1ns/100ps
// Debug unit checker
// Bound assertions on processor control exclusivity and transmit stream stability
module debug_unit_checker
    import dbg_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_imem_we,
    input  logic              i_cpu_enable,
    input  logic              i_dump_req,
    input  logic              i_dump_ready,
    input  logic [BYTE_W-1:0] i_tx_data,
    input  logic              i_tx_valid,
    input  logic              i_tx_ready
);

    int fail_count = 0;    // Read by the testbench summary

    we_enable_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_imem_we && i_cpu_enable))
        else begin fail_count++; $error("Instruction write while processor enabled"); end

    // Dumper busy or request outstanding means the loader holds the processor
    enable_in_dump: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_dump_req || !i_dump_ready) |-> !i_cpu_enable)
        else begin fail_count++; $error("Processor enabled while a dump is pending"); end

    tx_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
        else begin fail_count++; $error("Transmit byte dropped or changed while stalled"); end

endmodule

bind debug_unit debug_unit_checker checker_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_imem_we    (o_imem_we),
    .i_cpu_enable (o_cpu_enable),
    .i_dump_req   (dump_req),
    .i_dump_ready (dump_ready),
    .i_tx_data    (o_tx_data),
    .i_tx_valid   (o_tx_valid),
    .i_tx_ready   (i_tx_ready)
);

// ==== dv/debug_unit_tb.sv ====
`timescale 1ns/100ps
// Debug unit testbench
// Models the processor and the host link, and runs directed tests for
// program load, ignored commands, step, run to halt and transmit stalls.
module debug_unit_tb
    import dbg_pkg::*;
();

    localparam int WORD_SZ    = DEF_WORD_SZ;
    localparam int NUM_REGS   = 8;
    localparam int NUM_MEM    = 4;
    localparam int WBYTES     = WORD_SZ / BYTE_W;
    localparam int DUMP_BYTES = (NUM_REGS + NUM_MEM + 1) * WBYTES;
    localparam int TIMEOUT    = 2000;    // Cycles per wait
    localparam int DRV        = 2;       // Drive delay after the rising edge

    logic               i_clk;
    logic               i_reset;
    logic [BYTE_W-1:0]  i_rx_data;
    logic               i_rx_valid;
    logic               o_rx_ready;
    logic [BYTE_W-1:0]  o_tx_data;
    logic               o_tx_valid;
    logic               i_tx_ready;
    logic               i_cpu_halt;
    logic [WORD_SZ-1:0] i_reg_data;
    logic [WORD_SZ-1:0] i_mem_data;
    logic [WORD_SZ-1:0] i_pc;
    logic               o_imem_we;
    logic [7:0]         o_imem_addr;
    logic [WORD_SZ-1:0] o_imem_data;
    logic               o_cpu_enable;
    logic [7:0]         o_dbg_addr;

    logic [31:0]        lfsr = 32'he7cd_6fa3;
    logic [WORD_SZ-1:0] cpu_pc = '0;         // Processor model program counter
    int                 en_count = 0;        // Enable cycles seen
    int                 error_count = 0;
    int                 check_count = 0;
    logic [7:0]         tx_q [$];
    logic [7:0]         wr_addr_q [$];
    logic [31:0]        wr_data_q [$];

    debug_unit #(
        .WORD_SZ    (WORD_SZ),
        .ADDR_W     (8),
        .NUM_REGS   (NUM_REGS),
        .NUM_MEM    (NUM_MEM),
        .FIFO_DEPTH (4)
    ) dut_i (.*);

    function automatic logic [31:0] reg_word(input logic [7:0] a);
        return {8'hA0 + a, 24'h000000} | {24'h000000, a};
    endfunction

    function automatic logic [31:0] mem_word(input logic [7:0] a);
        return {8'hB0 + a, 24'h000000} | {24'h000000, a};
    endfunction

    assign i_reg_data = reg_word(o_dbg_addr);    // Combinational reads
    assign i_mem_data = mem_word(o_dbg_addr);
    assign i_pc       = cpu_pc;

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(input int n);
        int val;
        int i;
        val = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = (val << 1) | lfsr[0];
        end
        return val;
    endfunction

    function automatic logic [7:0] dump_byte(input int idx, input logic [31:0] pc);
        int          w;
        logic [31:0] word;
        w = idx / WBYTES;
        if (w < NUM_REGS)
            word = reg_word(w[7:0]);
        else if (w < NUM_REGS + NUM_MEM)
            word = mem_word(8'(w - NUM_REGS));
        else
            word = pc;
        return word[(idx % WBYTES) * BYTE_W +: BYTE_W];
    endfunction

    task automatic collect_tx_bytes();
        forever
        begin
            @(negedge i_clk);
            if (o_tx_valid && i_tx_ready)
                tx_q.push_back(o_tx_data);    // Taken at the next rising edge
        end
    endtask

    task automatic record_imem_writes();
        forever
        begin
            @(negedge i_clk);
            if (o_imem_we)
            begin
                wr_addr_q.push_back(o_imem_addr);
                wr_data_q.push_back(o_imem_data);
            end
        end
    endtask

    initial collect_tx_bytes();
    initial record_imem_writes();

    initial
    begin : cpu_model
        logic en;
        forever
        begin
            @(negedge i_clk);
            en = o_cpu_enable;
            if (en)
                en_count++;
            @(posedge i_clk);
            #DRV;
            if (en)
                cpu_pc = cpu_pc + 1'b1;    // One instruction per enabled cycle
        end
    end

    task automatic next_cycle();
        @(posedge i_clk);
        #DRV;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut_i.checker_i.fail_count);
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout: gave up waiting for %s", what);
        error_count++;
        print_summary();
        $display("Test failures found");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp)
        else
        begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic clear_queues();
        tx_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
    endtask

    // Returns right after the edge that takes the byte
    task automatic offer_byte(input logic [7:0] b);
        int cycles;
        cycles     = 0;
        i_rx_data  = b;
        i_rx_valid = 1'b1;
        while (!o_rx_ready)
        begin
            if (cycles == TIMEOUT)
                timeout_abort("receive FIFO ready");
            next_cycle();
            cycles++;
        end
        next_cycle();    // Byte accepted at this edge
        i_rx_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        offer_byte(b);
        idle_cycles(rand_bits(2));    // Random gap
    endtask

    task automatic send_word(input logic [31:0] w);
        int i;
        for (i = 0; i < WBYTES; i++)
            send_byte(w[i*BYTE_W +: BYTE_W]);    // LSB first
    endtask

    task automatic wait_writes(input int n, input string what);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < n)
        begin
            if (cycles == TIMEOUT)
                timeout_abort(what);
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_enable(input string what);
        int cycles;
        cycles = 0;
        while (!o_cpu_enable)
        begin
            if (cycles == TIMEOUT)
                timeout_abort(what);
            next_cycle();
            cycles++;
        end
    endtask

    // Optionally stalls the host side in random stretches
    task automatic wait_tx_bytes(input int n, input bit stall, input string what);
        int cycles;
        int stretch;
        cycles  = 0;
        stretch = 0;
        while (tx_q.size() < n)
        begin
            if (cycles == TIMEOUT)
                timeout_abort(what);
            if (stall)
            begin
                if (stretch == 0)
                begin
                    i_tx_ready = (rand_bits(1) != 0);
                    stretch    = 1 + rand_bits(3);
                end
                stretch--;
            end
            next_cycle();
            cycles++;
        end
        i_tx_ready = 1'b1;
    endtask

    task automatic check_dump(input string name, input logic [31:0] exp_pc);
        int i;
        check_value({name, " length"}, DUMP_BYTES, tx_q.size());
        for (i = 0; (i < DUMP_BYTES) && (i < tx_q.size()); i++)
            check_value($sformatf("%s byte %0d", name, i), dump_byte(i, exp_pc), tx_q[i]);
    endtask

    task automatic check_single_load(input string name, input logic [31:0] w);
        clear_queues();
        send_byte(CMD_LOAD);
        send_byte(8'd1);
        send_word(w);
        wait_writes(1, {name, " write"});
        idle_cycles(8);
        check_value({name, " writes"}, 1, wr_addr_q.size());
        check_value({name, " addr"}, 0, wr_addr_q[0]);
        check_value({name, " data"}, w, wr_data_q[0]);
    endtask

    task automatic check_reset_state();
        check_value("reset tx_valid", 0, o_tx_valid);
        check_value("reset imem_we", 0, o_imem_we);
        check_value("reset cpu_enable", 0, o_cpu_enable);
        check_value("reset rx_ready", 1, o_rx_ready);
        check_value("reset dbg_addr", 0, o_dbg_addr);
    endtask

    task automatic test_program_load();
        logic [31:0] words [3];
        int          i;
        words = '{32'h1234_5678, 32'hDEAD_BEEF, 32'h0BAD_F00D};
        clear_queues();
        send_byte(CMD_LOAD);
        send_byte(8'd3);
        for (i = 0; i < 3; i++)
            send_word(words[i]);
        wait_writes(3, "program load writes");
        idle_cycles(8);
        check_value("load writes", 3, wr_addr_q.size());
        for (i = 0; i < 3; i++)
        begin
            check_value("load addr", i, wr_addr_q[i]);
            check_value("load data", words[i], wr_data_q[i]);
        end
        clear_queues();
        send_byte(CMD_LOAD);
        send_byte(8'd0);    // Empty program
        idle_cycles(12);
        check_value("empty load writes", 0, wr_addr_q.size());
    endtask

    task automatic test_ignored_cmd();
        int en_before;
        en_before = en_count;
        send_byte(8'h55);    // Not a command
        check_single_load("ignored cmd load", 32'hCAFE_0001);
        check_value("ignored cmd tx bytes", 0, tx_q.size());
        check_value("ignored cmd enable", 0, en_count - en_before);
    endtask

    task automatic step_once(input string name, input bit stall);
        logic [31:0] pc_before;
        int          en_before;
        pc_before = cpu_pc;
        en_before = en_count;
        tx_q.delete();
        send_byte(CMD_NEXT);
        wait_tx_bytes(DUMP_BYTES, stall, {name, " bytes"});
        idle_cycles(6);
        check_value({name, " enable cycles"}, 1, en_count - en_before);
        check_dump(name, pc_before + 1);
    endtask

    task automatic test_step_mode();
        send_byte(CMD_STEP);
        step_once("step 1 dump", 1'b0);
        step_once("step 2 dump", 1'b0);
        send_byte(CMD_END);
    endtask

    task automatic test_run_to_halt();
        logic [31:0] pc_before;
        int          en_before;
        int          n;
        pc_before = cpu_pc;
        en_before = en_count;
        n         = 3 + rand_bits(3);
        tx_q.delete();
        offer_byte(CMD_RUN);    // No gap, enable rises after this returns
        wait_enable("run enable");
        idle_cycles(n);
        i_cpu_halt = 1'b1;
        next_cycle();    // Halt sampled at this edge
        check_value("run enable drop", 0, o_cpu_enable);
        i_cpu_halt = 1'b0;
        wait_tx_bytes(DUMP_BYTES, 1'b0, "run dump bytes");
        idle_cycles(6);
        check_value("run enable cycles", n + 1, en_count - en_before);
        check_dump("run dump", pc_before + n + 1);
        check_single_load("load after run", 32'h600D_0002);
        check_value("after run tx bytes", 0, tx_q.size());
    endtask

    task automatic test_back_pressure();
        send_byte(CMD_STEP);
        step_once("stalled dump", 1'b1);
        send_byte(CMD_END);
    endtask

    initial
    begin
        i_reset    = 1'b1;
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        i_tx_ready = 1'b1;
        i_cpu_halt = 1'b0;
        repeat (4) @(posedge i_clk);
        #DRV;
        i_reset = 1'b0;
        check_reset_state();
        test_program_load();
        test_ignored_cmd();
        test_step_mode();
        test_run_to_halt();
        test_back_pressure();
        idle_cycles(4);
        print_summary();
        if ((error_count == 0) && (dut_i.checker_i.fail_count == 0))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/100ps
// Byte FIFO
// Circular buffer with valid/ready handshakes on the write and read sides.
// Read data comes straight from the slot at the read pointer.
module byte_fifo
#(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 4
)
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [DATA_W-1:0] i_in_data,
    input  logic              i_in_valid,
    output logic              o_in_ready,
    output logic [DATA_W-1:0] o_out_data,
    output logic              o_out_valid,
    input  logic              i_out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_CNT = DEPTH[PTR_W:0];

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;       // Occupancy
    logic              push;
    logic              pop;

    assign o_in_ready  = (count != FULL_CNT);
    assign o_out_valid = (count != '0);
    assign o_out_data  = mem[rd_ptr];

    assign push = i_in_valid && o_in_ready;
    assign pop  = o_out_valid && i_out_ready;

    always_ff @(posedge i_clk)
    begin
        if (push)
            mem[wr_ptr] <= i_in_data;
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

endmodule

// ==== hdl/cmd_loader.sv ====
`timescale 1ns/100ps
// Command loader
// Decodes host command bytes, assembles instructions for the instruction
// memory and decides when the processor runs and when a dump is sent.
module cmd_loader
    import dbg_pkg::*;
#(
    parameter int WORD_SZ = DEF_WORD_SZ,
    parameter int ADDR_W  = 8
)
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [BYTE_W-1:0]  i_rx_data,
    input  logic               i_rx_valid,
    output logic               o_rx_ready,
    output logic               o_dump_req,
    input  logic               i_dump_ready,
    input  logic               i_dump_done,
    input  logic               i_cpu_halt,
    output logic               o_imem_we,
    output logic [ADDR_W-1:0]  o_imem_addr,
    output logic [WORD_SZ-1:0] o_imem_data,
    output logic               o_cpu_enable
);

    localparam int BYTES  = WORD_SZ / BYTE_W;
    localparam int BCNT_W = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam logic [BCNT_W-1:0] LAST_BYTE = BCNT_W'(BYTES - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PROG_SIZE,
        ST_INST_BYTE,
        ST_INST_WRITE,
        ST_STEP_WAIT,
        ST_STEP_EXEC,
        ST_RUNNING,
        ST_DUMP_WAIT
    } state_t;

    state_t             state, state_next;
    logic [BYTE_W-1:0]  prog_size, prog_size_next;    // Instructions to load
    logic [BYTE_W-1:0]  inst_cnt, inst_cnt_next;      // Instructions written
    logic [BCNT_W-1:0]  byte_cnt, byte_cnt_next;      // Bytes of current instruction
    logic [WORD_SZ-1:0] inst_reg, inst_reg_next;
    logic               step_mode, step_mode_next;    // Where to go after a dump
    logic               req_sent, req_sent_next;      // Dump request accepted
    logic               rx_take;
    logic               more_inst;

    assign rx_take   = i_rx_valid && o_rx_ready;
    assign more_inst = ((inst_cnt + 1'b1) != prog_size);

    assign o_imem_we    = (state == ST_INST_WRITE);
    assign o_imem_addr  = ADDR_W'(inst_cnt);
    assign o_imem_data  = inst_reg;
    assign o_cpu_enable = (state == ST_STEP_EXEC) || (state == ST_RUNNING);
    assign o_dump_req   = (state == ST_DUMP_WAIT) && !req_sent;

    always_comb
    begin
        case (state)
            ST_IDLE, ST_PROG_SIZE, ST_INST_BYTE, ST_STEP_WAIT:
                o_rx_ready = 1'b1;
            ST_INST_WRITE:
                o_rx_ready = more_inst;    // Next instruction may start here
            default:
                o_rx_ready = 1'b0;
        endcase
    end

    always_comb
    begin
        state_next     = state;
        prog_size_next = prog_size;
        inst_cnt_next  = inst_cnt;
        byte_cnt_next  = byte_cnt;
        inst_reg_next  = inst_reg;
        step_mode_next = step_mode;
        req_sent_next  = req_sent;

        case (state)
            ST_IDLE:
            begin
                if (rx_take)
                begin
                    case (i_rx_data)
                        CMD_LOAD: state_next = ST_PROG_SIZE;
                        CMD_STEP: state_next = ST_STEP_WAIT;
                        CMD_RUN:  state_next = ST_RUNNING;
                        default:  state_next = ST_IDLE;    // Unknown, dropped
                    endcase
                end
            end
            ST_PROG_SIZE:
            begin
                if (rx_take)
                begin
                    prog_size_next = i_rx_data;
                    inst_cnt_next  = '0;
                    byte_cnt_next  = '0;
                    state_next     = (i_rx_data == '0) ? ST_IDLE : ST_INST_BYTE;
                end
            end
            ST_INST_BYTE:
                state_next = ST_INST_BYTE;    // Left by the byte logic below
            ST_INST_WRITE:
            begin
                inst_cnt_next = inst_cnt + 1'b1;
                state_next    = more_inst ? ST_INST_BYTE : ST_IDLE;
            end
            ST_STEP_WAIT:
            begin
                if (rx_take && (i_rx_data == CMD_NEXT))
                    state_next = ST_STEP_EXEC;
                else if (rx_take && (i_rx_data == CMD_END))
                    state_next = ST_IDLE;
            end
            ST_STEP_EXEC:
            begin
                step_mode_next = 1'b1;
                req_sent_next  = 1'b0;
                state_next     = ST_DUMP_WAIT;
            end
            ST_RUNNING:
            begin
                if (i_cpu_halt)
                begin
                    step_mode_next = 1'b0;
                    req_sent_next  = 1'b0;
                    state_next     = ST_DUMP_WAIT;
                end
            end
            ST_DUMP_WAIT:
            begin
                if (o_dump_req && i_dump_ready)
                    req_sent_next = 1'b1;
                if (req_sent && i_dump_done)
                    state_next = step_mode ? ST_STEP_WAIT : ST_IDLE;
            end
            default:
                state_next = ST_IDLE;
        endcase

        // Instruction bytes arrive LSB first and shift in from the top
        if (rx_take && ((state == ST_INST_BYTE) || (state == ST_INST_WRITE)))
        begin
            inst_reg_next = (inst_reg >> BYTE_W)
                          | (WORD_SZ'(i_rx_data) << (WORD_SZ - BYTE_W));
            byte_cnt_next = byte_cnt + 1'b1;
            if (byte_cnt == LAST_BYTE)
            begin
                byte_cnt_next = '0;
                state_next    = ST_INST_WRITE;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state     <= ST_IDLE;
            prog_size <= '0;
            inst_cnt  <= '0;
            byte_cnt  <= '0;
            step_mode <= 1'b0;
            req_sent  <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            prog_size <= prog_size_next;
            inst_cnt  <= inst_cnt_next;
            byte_cnt  <= byte_cnt_next;
            step_mode <= step_mode_next;
            req_sent  <= req_sent_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        inst_reg <= inst_reg_next;
    end

endmodule

// ==== hdl/dbg_pkg.sv ====
// Debug unit shared definitions
// Host command codes, link byte width and default dump sizes
package dbg_pkg;

    // Link byte width
    localparam int BYTE_W = 8;

    // Host command codes
    localparam logic [BYTE_W-1:0] CMD_LOAD = 8'hFE;    // Start program load
    localparam logic [BYTE_W-1:0] CMD_STEP = 8'hFC;    // Enter step mode
    localparam logic [BYTE_W-1:0] CMD_RUN  = 8'hF0;    // Run until halt
    localparam logic [BYTE_W-1:0] CMD_NEXT = 8'h01;    // One cycle, then dump
    localparam logic [BYTE_W-1:0] CMD_END  = 8'hF8;    // Leave step mode

    // Default sizes
    localparam int DEF_NUM_REGS = 32;    // Registers in a dump
    localparam int DEF_NUM_MEM  = 32;    // Memory words in a dump
    localparam int DEF_WORD_SZ  = 32;    // Instruction, data and PC width

endpackage

// ==== hdl/debug_unit.sv ====
`timescale 1ns/100ps
// Debug unit top level
// Receive FIFO feeds the command loader, the state dumper feeds the
// transmit FIFO, and the loader hands dump requests to the dumper.
module debug_unit
    import dbg_pkg::*;
#(
    parameter int WORD_SZ    = DEF_WORD_SZ,
    parameter int ADDR_W     = 8,
    parameter int NUM_REGS   = DEF_NUM_REGS,
    parameter int NUM_MEM    = DEF_NUM_MEM,
    parameter int FIFO_DEPTH = 16
)
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic [BYTE_W-1:0]  i_rx_data,
    input  logic               i_rx_valid,
    output logic               o_rx_ready,
    output logic [BYTE_W-1:0]  o_tx_data,
    output logic               o_tx_valid,
    input  logic               i_tx_ready,
    input  logic               i_cpu_halt,
    input  logic [WORD_SZ-1:0] i_reg_data,
    input  logic [WORD_SZ-1:0] i_mem_data,
    input  logic [WORD_SZ-1:0] i_pc,
    output logic               o_imem_we,
    output logic [ADDR_W-1:0]  o_imem_addr,
    output logic [WORD_SZ-1:0] o_imem_data,
    output logic               o_cpu_enable,
    output logic [ADDR_W-1:0]  o_dbg_addr
);

    logic [BYTE_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_ready;
    logic [BYTE_W-1:0] tx_byte;
    logic              tx_byte_valid;
    logic              tx_byte_ready;
    logic              dump_req;
    logic              dump_ready;
    logic              dump_done;

    byte_fifo #(
        .DATA_W (BYTE_W),
        .DEPTH  (FIFO_DEPTH)
    ) rx_fifo_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_in_data   (i_rx_data),
        .i_in_valid  (i_rx_valid),
        .o_in_ready  (o_rx_ready),
        .o_out_data  (rx_data),
        .o_out_valid (rx_valid),
        .i_out_ready (rx_ready)
    );

    cmd_loader #(
        .WORD_SZ (WORD_SZ),
        .ADDR_W  (ADDR_W)
    ) loader_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_data    (rx_data),
        .i_rx_valid   (rx_valid),
        .o_rx_ready   (rx_ready),
        .o_dump_req   (dump_req),
        .i_dump_ready (dump_ready),
        .i_dump_done  (dump_done),
        .i_cpu_halt   (i_cpu_halt),
        .o_imem_we    (o_imem_we),
        .o_imem_addr  (o_imem_addr),
        .o_imem_data  (o_imem_data),
        .o_cpu_enable (o_cpu_enable)
    );

    state_dumper #(
        .WORD_SZ  (WORD_SZ),
        .ADDR_W   (ADDR_W),
        .NUM_REGS (NUM_REGS),
        .NUM_MEM  (NUM_MEM)
    ) dumper_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_dump_req   (dump_req),
        .o_dump_ready (dump_ready),
        .o_dump_done  (dump_done),
        .o_dbg_addr   (o_dbg_addr),     // Register and data memory read address
        .i_reg_data   (i_reg_data),
        .i_mem_data   (i_mem_data),
        .i_pc         (i_pc),
        .o_tx_data    (tx_byte),
        .o_tx_valid   (tx_byte_valid),
        .i_tx_ready   (tx_byte_ready)
    );

    byte_fifo #(
        .DATA_W (BYTE_W),
        .DEPTH  (FIFO_DEPTH)
    ) tx_fifo_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_in_data   (tx_byte),
        .i_in_valid  (tx_byte_valid),
        .o_in_ready  (tx_byte_ready),
        .o_out_data  (o_tx_data),
        .o_out_valid (o_tx_valid),
        .i_out_ready (i_tx_ready)
    );

endmodule

// ==== hdl/state_dumper.sv ====
`timescale 1ns/100ps
// State dumper
// Walks the register file, the data memory and the program counter and
// sends each word LSB first as link bytes.
module state_dumper
    import dbg_pkg::*;
#(
    parameter int WORD_SZ  = DEF_WORD_SZ,
    parameter int ADDR_W   = 8,
    parameter int NUM_REGS = DEF_NUM_REGS,
    parameter int NUM_MEM  = DEF_NUM_MEM
)
(
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_dump_req,
    output logic               o_dump_ready,
    output logic               o_dump_done,
    output logic [ADDR_W-1:0]  o_dbg_addr,
    input  logic [WORD_SZ-1:0] i_reg_data,
    input  logic [WORD_SZ-1:0] i_mem_data,
    input  logic [WORD_SZ-1:0] i_pc,
    output logic [BYTE_W-1:0]  o_tx_data,
    output logic               o_tx_valid,
    input  logic               i_tx_ready
);

    localparam int BYTES  = WORD_SZ / BYTE_W;
    localparam int BIDX_W = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam logic [BIDX_W-1:0] LAST_BYTE = BIDX_W'(BYTES - 1);
    localparam logic [ADDR_W-1:0] LAST_REG  = ADDR_W'(NUM_REGS - 1);
    localparam logic [ADDR_W-1:0] LAST_MEM  = ADDR_W'(NUM_MEM - 1);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_REGS,
        PH_MEM,
        PH_PC
    } phase_t;

    phase_t             phase;
    logic [ADDR_W-1:0]  addr;         // Word being sent
    logic [BIDX_W-1:0]  byte_idx;     // Byte within word
    logic [WORD_SZ-1:0] word;
    logic               send;
    logic               last_byte;
    logic               done_q;

    always_comb
    begin
        case (phase)
            PH_REGS: word = i_reg_data;
            PH_MEM:  word = i_mem_data;
            default: word = i_pc;
        endcase
    end

    assign o_tx_data    = word[byte_idx*BYTE_W +: BYTE_W];
    assign o_tx_valid   = (phase != PH_IDLE);
    assign o_dump_ready = (phase == PH_IDLE);
    assign o_dump_done  = done_q;
    assign o_dbg_addr   = addr;
    assign send         = o_tx_valid && i_tx_ready;
    assign last_byte    = (byte_idx == LAST_BYTE);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            phase    <= PH_IDLE;
            addr     <= '0;
            byte_idx <= '0;
            done_q   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (phase == PH_IDLE)
            begin
                if (i_dump_req)
                begin
                    phase    <= PH_REGS;
                    addr     <= '0;
                    byte_idx <= '0;
                end
            end
            else if (send)     // Stalled otherwise, address and index held
            begin
                byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
                if (last_byte)
                begin
                    case (phase)
                        PH_REGS:
                        begin
                            addr  <= (addr == LAST_REG) ? '0 : addr + 1'b1;
                            phase <= (addr == LAST_REG) ? PH_MEM : PH_REGS;
                        end
                        PH_MEM:
                        begin
                            addr  <= (addr == LAST_MEM) ? '0 : addr + 1'b1;
                            phase <= (addr == LAST_MEM) ? PH_PC : PH_MEM;
                        end
                        default:
                        begin
                            phase  <= PH_IDLE;
                            done_q <= 1'b1;    // Final PC byte taken
                        end
                    endcase
                end
            end
        end
    end

endmodule
